// ==== rtl/ps2KeyPkg.sv ====
package ps2KeyPkg;

    // ********************
    // byte widths
    // ********************

    // one byte as it arrives from the keyboard
    typedef logic [7:0] scanCode_t;

    // one character as seen by the host
    typedef logic [7:0] asciiChar_t;

    // ********************
    // tracker state
    // ********************

    // prefix state machine
    // keyRelease follows F0, keyExtended follows E0
    // keyExtRelease follows E0 F0
    typedef enum logic [1:0]
    {
        keyNormal,
        keyRelease,
        keyExtended,
        keyExtRelease
    } trackerState_t;

    // ********************
    // block results
    // ********************

    // tracker verdict on one scan code
    typedef struct packed
    {
        // non-shift make code that passed debounce
        logic accept;
        // shift state in effect for that code
        logic shift;
    } keyEvent_t;

    // translator output for one scan code
    typedef struct packed
    {
        // unshifted character
        asciiChar_t lower;
        // shifted character
        asciiChar_t upper;
    } charPair_t;

endpackage

// ==== rtl/ps2Receiver.sv ====
module ps2Receiver
(
    input  logic                 clk25,
    input  logic                 rst,
    input  logic                 keyClk,
    input  logic                 keyData,
    output logic                 scanStb,
    output logic                 parityErrStb,
    output ps2KeyPkg::scanCode_t scanCode
);

    // ********************
    // keyboard clock side
    // ********************

    // bits shifted in so far
    logic [3:0]  bitCnt;
    // lsb first, start bit ends up in bit 0
    logic [10:0] shiftReg;
    // toggles once per finished frame
    logic        frameFlag;
    // finished frame, stable until the next one completes
    logic [10:0] frameReg;

    // ********************
    // clk25 side
    // ********************

    // two-flop synchronizer for the toggle flag
    logic [1:0]  flagSync;
    // last synchronized value, for the edge detector
    logic        flagPrev;
    logic        newFrame;
    logic        frameOk;

    // keyboard drives data while its clock is high
    // so sample on the falling edge
    always_ff @(negedge keyClk or posedge rst)
    begin
        if (rst)
        begin
            bitCnt    <= '0;
            shiftReg  <= '0;
            frameFlag <= 1'b0;
        end
        else
        begin
            shiftReg <= {keyData, shiftReg[10:1]};
            if (bitCnt == 4'd10)
            begin
                // eleventh bit, frame complete
                bitCnt    <= '0;
                frameFlag <= ~frameFlag;
            end
            else
            begin
                bitCnt <= bitCnt + 4'd1;
            end
        end
    end

    // capture the whole frame together with the last bit
    always_ff @(negedge keyClk)
    begin
        if (bitCnt == 4'd10)
        begin
            frameReg <= {keyData, shiftReg[10:1]};
        end
    end

    // one cycle after the synchronized flag changes
    assign newFrame = flagSync[1] ^ flagPrev;

    // start 0, stop 1, odd parity over data and parity bits
    assign frameOk = ~frameReg[0] & frameReg[10] & (^frameReg[9:1]);

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            flagSync     <= '0;
            flagPrev     <= 1'b0;
            scanStb      <= 1'b0;
            parityErrStb <= 1'b0;
        end
        else
        begin
            flagSync     <= {flagSync[0], frameFlag};
            flagPrev     <= flagSync[1];
            scanStb      <= newFrame & frameOk;
            parityErrStb <= newFrame & ~frameOk;
        end
    end

    // data byte sits between start and parity bits
    always_ff @(posedge clk25)
    begin
        if (newFrame)
        begin
            scanCode <= frameReg[8:1];
        end
    end

endmodule

// ==== rtl/keyStateTracker.sv ====
module keyStateTracker
#(
    parameter int debounceCycles = 65535
)
(
    input  logic                 clk25,
    input  logic                 rst,
    input  logic                 scanStb,
    input  ps2KeyPkg::scanCode_t scanCode,
    output logic                 eventStb,
    output ps2KeyPkg::keyEvent_t keyEvent
);

    // timer wide enough to hold the reload value
    localparam int timerWidth = $clog2(debounceCycles + 1);

    // prefix and shift codes, scan code set 2
    localparam ps2KeyPkg::scanCode_t codeRelease    = 8'hF0;
    localparam ps2KeyPkg::scanCode_t codeExtended   = 8'hE0;
    localparam ps2KeyPkg::scanCode_t codeShiftLeft  = 8'h12;
    localparam ps2KeyPkg::scanCode_t codeShiftRight = 8'h59;

    ps2KeyPkg::trackerState_t state;
    logic                     shiftHeld;
    logic [timerWidth-1:0]    timer;
    logic                     isShift;

    assign isShift = (scanCode == codeShiftLeft) || (scanCode == codeShiftRight);

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            state     <= ps2KeyPkg::keyNormal;
            shiftHeld <= 1'b0;
            timer     <= '0;
            eventStb  <= 1'b0;
            keyEvent  <= '0;
        end
        else
        begin
            // one event per scan code, one cycle later
            eventStb <= scanStb;

            // free-running countdown, a load below wins
            if (timer != '0)
            begin
                timer <= timer - 1'b1;
            end

            if (scanStb)
            begin
                keyEvent.accept <= 1'b0;
                keyEvent.shift  <= shiftHeld;
                case (state)
                    ps2KeyPkg::keyNormal:
                    begin
                        if (scanCode == codeRelease)
                        begin
                            state <= ps2KeyPkg::keyRelease;
                        end
                        else if (scanCode == codeExtended)
                        begin
                            state <= ps2KeyPkg::keyExtended;
                        end
                        else if (isShift)
                        begin
                            // shift make, held but not reported
                            shiftHeld <= 1'b1;
                        end
                        else if (timer == '0)
                        begin
                            // key accepted, start the quiet window
                            keyEvent.accept <= 1'b1;
                            timer           <= timerWidth'(debounceCycles);
                        end
                    end
                    ps2KeyPkg::keyRelease:
                    begin
                        // only shift releases matter
                        if (isShift)
                        begin
                            shiftHeld <= 1'b0;
                        end
                        state <= ps2KeyPkg::keyNormal;
                    end
                    ps2KeyPkg::keyExtended:
                    begin
                        if (scanCode == codeRelease)
                        begin
                            state <= ps2KeyPkg::keyExtRelease;
                        end
                        else
                        begin
                            state <= ps2KeyPkg::keyNormal;
                        end
                    end
                    default:
                    begin
                        // extended release, drop it
                        state <= ps2KeyPkg::keyNormal;
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/scanTranslator.sv ====
module scanTranslator
(
    input  logic                 clk25,
    input  logic                 rst,
    input  logic                 scanStb,
    input  ps2KeyPkg::scanCode_t scanCode,
    output ps2KeyPkg::charPair_t charPair
);

    ps2KeyPkg::asciiChar_t lowerChar;
    ps2KeyPkg::asciiChar_t upperChar;

    // ********************
    // unshifted table
    // ********************
    always_comb
    begin
        case (scanCode)
            // letters, always upper case
            8'h1C: lowerChar = "A";
            8'h32: lowerChar = "B";
            8'h21: lowerChar = "C";
            8'h23: lowerChar = "D";
            8'h24: lowerChar = "E";
            8'h2B: lowerChar = "F";
            8'h34: lowerChar = "G";
            8'h33: lowerChar = "H";
            8'h43: lowerChar = "I";
            8'h3B: lowerChar = "J";
            8'h42: lowerChar = "K";
            8'h4B: lowerChar = "L";
            8'h3A: lowerChar = "M";
            8'h31: lowerChar = "N";
            8'h44: lowerChar = "O";
            8'h4D: lowerChar = "P";
            8'h15: lowerChar = "Q";
            8'h2D: lowerChar = "R";
            8'h1B: lowerChar = "S";
            8'h2C: lowerChar = "T";
            8'h3C: lowerChar = "U";
            8'h2A: lowerChar = "V";
            8'h1D: lowerChar = "W";
            8'h22: lowerChar = "X";
            8'h35: lowerChar = "Y";
            8'h1A: lowerChar = "Z";
            // top row digits
            8'h45: lowerChar = "0";
            8'h16: lowerChar = "1";
            8'h1E: lowerChar = "2";
            8'h26: lowerChar = "3";
            8'h25: lowerChar = "4";
            8'h2E: lowerChar = "5";
            8'h36: lowerChar = "6";
            8'h3D: lowerChar = "7";
            8'h3E: lowerChar = "8";
            8'h46: lowerChar = "9";
            // punctuation
            8'h4E: lowerChar = "-";
            8'h55: lowerChar = "=";
            8'h5D: lowerChar = "\\";
            8'h54: lowerChar = "[";
            8'h5B: lowerChar = "]";
            8'h4C: lowerChar = ";";
            8'h52: lowerChar = "'";
            8'h41: lowerChar = ",";
            8'h49: lowerChar = ".";
            8'h4A: lowerChar = "/";
            // space, backspace, enter
            8'h29: lowerChar = " ";
            8'h66: lowerChar = 8'd8;
            8'h5A: lowerChar = 8'd13;
            default: lowerChar = ".";
        endcase
    end

    // ********************
    // shifted table
    // ********************
    // only keys whose shifted char differs are listed
    always_comb
    begin
        case (scanCode)
            8'h45: upperChar = ")";
            8'h16: upperChar = "!";
            8'h1E: upperChar = "@";
            8'h26: upperChar = "#";
            8'h25: upperChar = "$";
            8'h2E: upperChar = "%";
            8'h36: upperChar = "^";
            8'h3D: upperChar = "&";
            8'h3E: upperChar = "*";
            8'h46: upperChar = "(";
            8'h4E: upperChar = "_";
            8'h55: upperChar = "+";
            8'h5D: upperChar = "|";
            8'h54: upperChar = "{";
            8'h5B: upperChar = "}";
            8'h4C: upperChar = ":";
            8'h52: upperChar = "\"";
            8'h41: upperChar = "<";
            8'h49: upperChar = ">";
            8'h4A: upperChar = "?";
            // letters, space, enter, backspace, unknown
            default: upperChar = lowerChar;
        endcase
    end

    // pair lines up with the tracker event
    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            charPair <= '0;
        end
        else if (scanStb)
        begin
            charPair.lower <= lowerChar;
            charPair.upper <= upperChar;
        end
    end

endmodule

// ==== rtl/hostPort.sv ====
module hostPort
(
    input  logic                  clk25,
    input  logic                  rst,
    input  logic                  eventStb,
    input  ps2KeyPkg::keyEvent_t  keyEvent,
    input  ps2KeyPkg::charPair_t  charPair,
    input  logic                  parityErrStb,
    input  logic                  cs,
    input  logic                  address,
    output ps2KeyPkg::asciiChar_t dout
);

    // single character buffer, newest key wins
    ps2KeyPkg::asciiChar_t charBuf;
    logic                  ready;
    logic                  parityErr;
    logic                  newKey;

    assign newKey = eventStb & keyEvent.accept;

    always_ff @(posedge clk25)
    begin
        if (newKey)
        begin
            charBuf <= keyEvent.shift ? charPair.upper : charPair.lower;
        end
    end

    // ********************
    // status and read bus
    // ********************
    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            ready     <= 1'b0;
            parityErr <= 1'b0;
            dout      <= '0;
        end
        else
        begin
            if (cs)
            begin
                if (!address)
                begin
                    // data read, bit 7 always set
                    dout  <= {1'b1, charBuf[6:0]};
                    ready <= 1'b0;
                end
                else
                begin
                    // status read, clears the error flag
                    dout      <= {ready, parityErr, 6'b0};
                    parityErr <= 1'b0;
                end
            end
            // a new event beats a read in the same cycle
            if (newKey)
            begin
                ready <= 1'b1;
            end
            if (parityErrStb)
            begin
                parityErr <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/ps2Keyboard.sv ====
module ps2Keyboard
#(
    parameter int debounceCycles = 65535
)
(
    input  logic                  clk25,
    input  logic                  rst,
    input  logic                  keyClk,
    input  logic                  keyData,
    input  logic                  cs,
    input  logic                  address,
    output ps2KeyPkg::asciiChar_t dout
);

    // receiver outputs
    logic                 scanStb;
    logic                 parityErrStb;
    ps2KeyPkg::scanCode_t scanCode;

    // tracker and translator results
    logic                 eventStb;
    ps2KeyPkg::keyEvent_t keyEvent;
    ps2KeyPkg::charPair_t charPair;

    ps2Receiver i_receiver
    (
        .clk25        (clk25),
        .rst          (rst),
        .keyClk       (keyClk),
        .keyData      (keyData),
        .scanStb      (scanStb),
        .parityErrStb (parityErrStb),
        .scanCode     (scanCode)
    );

    // tracker and translator see the same code in parallel
    keyStateTracker #(.debounceCycles(debounceCycles)) i_tracker
    (
        .clk25    (clk25),
        .rst      (rst),
        .scanStb  (scanStb),
        .scanCode (scanCode),
        .eventStb (eventStb),
        .keyEvent (keyEvent)
    );

    scanTranslator i_translator
    (
        .clk25    (clk25),
        .rst      (rst),
        .scanStb  (scanStb),
        .scanCode (scanCode),
        .charPair (charPair)
    );

    hostPort i_hostPort
    (
        .clk25        (clk25),
        .rst          (rst),
        .eventStb     (eventStb),
        .keyEvent     (keyEvent),
        .charPair     (charPair),
        .parityErrStb (parityErrStb),
        .cs           (cs),
        .address      (address),
        .dout         (dout)
    );

endmodule

// ==== test/ps2KeyboardTb.sv ====
module ps2KeyboardTb;

    // keyboard clock is 40 units, so one frame is about 440 units
    localparam int gapCycles    = 320;
    localparam int frameCount   = 40;
    localparam int gapCount     = 28;
    localparam int watchdogTime = frameCount * 440 * 2 + gapCount * gapCycles * 4;

    logic                  clk25 = 1'b0;
    logic                  rst;
    logic                  keyClk;
    logic                  keyData;
    logic                  cs;
    logic                  address;
    ps2KeyPkg::asciiChar_t dout;

    int     errors;
    integer seed;

    // set 2 make codes for A to Z, in alphabet order
    logic [7:0] letterCodes [26] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
        8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
        8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
    };
    // top row keys 1 to 9, then 0
    logic [7:0] digitCodes [10] = '{
        8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45
    };

    ps2Keyboard #(.debounceCycles(300)) i_dut
    (
        .clk25   (clk25),
        .rst     (rst),
        .keyClk  (keyClk),
        .keyData (keyData),
        .cs      (cs),
        .address (address),
        .dout    (dout)
    );

    always #2 clk25 = ~clk25;

    // ********************
    // bus and frame helpers
    // ********************

    // start bit, 8 data bits lsb first, parity, stop bit
    task automatic sendFrame(input logic [7:0] code, input logic badParity);
        logic [10:0] frame;
        logic        parity;
        int          i;
        // odd parity, flipped on request
        parity = ~(^code) ^ badParity;
        frame  = {1'b1, parity, code, 1'b0};
        @(negedge clk25);
        for (i = 0; i < 11; i++)
        begin
            // data changes while keyClk is high
            keyData = frame[i];
            repeat (5) @(negedge clk25);
            keyClk = 1'b0;
            repeat (5) @(negedge clk25);
            keyClk = 1'b1;
        end
        keyData = 1'b1;
    endtask

    task automatic sendCode(input logic [7:0] code);
        sendFrame(code, 1'b0);
    endtask

    // one cycle of cs, dout sampled after the second rising edge
    task automatic readReg(input logic addr, output logic [7:0] value);
        @(negedge clk25);
        cs      = 1'b1;
        address = addr;
        @(negedge clk25);
        cs = 1'b0;
        @(posedge clk25);
        @(negedge clk25);
        value = dout;
    endtask

    task automatic readStatus(output logic [7:0] value);
        readReg(1'b1, value);
    endtask

    task automatic readData(output logic [7:0] value);
        readReg(1'b0, value);
    endtask

    task automatic checkByte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // poll the status register until ready shows up
    task automatic waitReady(output logic ok);
        logic [7:0] status;
        int         tries;
        ok    = 1'b0;
        tries = 0;
        while (!ok && tries < 20)
        begin
            readStatus(status);
            ok = status[7];
            tries++;
        end
        if (!ok)
        begin
            $display("ready bit did not come up within 20 status reads at time %0t", $time);
            errors++;
        end
    endtask

    // quiet time so the next key clears debounce
    task automatic debounceGap();
        repeat (gapCycles) @(negedge clk25);
    endtask

    // one key press, read back with bit 7 set, ready cleared after
    task automatic expectChar(input logic [7:0] code, input logic [7:0] exp);
        logic [7:0] value;
        logic       ok;
        sendCode(code);
        waitReady(ok);
        if (ok)
        begin
            readData(value);
            checkByte(value, {1'b1, exp[6:0]}, $sformatf("data for scan code %h", code));
            readStatus(value);
            checkByte(value, 8'h00, "status after data read");
        end
        debounceGap();
    endtask

    // the last frames must leave status empty
    task automatic expectIdle(input string what);
        logic [7:0] value;
        repeat (10) @(negedge clk25);
        readStatus(value);
        checkByte(value, 8'h00, what);
    endtask

    // ********************
    // tests
    // ********************

    task automatic testReset();
        logic [7:0] value;
        readStatus(value);
        checkByte(value, 8'h00, "status after reset");
        // buffer content is unknown here, only ready matters
        readData(value);
        readStatus(value);
        checkByte(value, 8'h00, "status after data read with no key");
    endtask

    task automatic testUnshifted();
        int idx;
        int n;
        for (n = 0; n < 8; n++)
        begin
            idx = {$random(seed)} % 26;
            expectChar(letterCodes[idx], 8'h41 + idx[7:0]);
        end
        for (n = 0; n < 10; n++)
        begin
            expectChar(digitCodes[n], (n == 9) ? 8'h30 : 8'h31 + n[7:0]);
        end
        expectChar(8'h29, 8'h20);
        expectChar(8'h5A, 8'd13);
        expectChar(8'h66, 8'd8);
    endtask

    task automatic testShift();
        sendCode(8'h12);
        expectIdle("status after shift make");
        expectChar(8'h1E, "@");
        expectChar(8'h4A, "?");
        // shift release
        sendCode(8'hF0);
        sendCode(8'h12);
        expectIdle("status after shift release");
        expectChar(8'h1E, "2");
    endtask

    task automatic testDebounce();
        logic [7:0] value;
        logic       ok;
        // second make lands well inside the 300 cycle window
        sendCode(8'h1C);
        sendCode(8'h1B);
        waitReady(ok);
        if (ok)
        begin
            readData(value);
            checkByte(value, 8'hC1, "first key kept during debounce");
        end
        debounceGap();
        expectChar(8'h2B, "F");
    endtask

    task automatic testParity();
        logic [7:0] value;
        sendFrame(8'h1C, 1'b1);
        repeat (10) @(negedge clk25);
        readStatus(value);
        checkByte(value, 8'h40, "status after bad parity frame");
        // flag is sticky until read once
        readStatus(value);
        checkByte(value, 8'h00, "status after parity flag read");
        expectChar(8'h24, "E");
    endtask

    task automatic testPrefixes();
        sendCode(8'hE0);
        sendCode(8'h75);
        expectIdle("status after extended make");
        sendCode(8'hE0);
        sendCode(8'hF0);
        sendCode(8'h75);
        expectIdle("status after extended release");
        sendCode(8'hF0);
        sendCode(8'h1C);
        expectIdle("status after key release");
        // unknown code falls back to a dot
        expectChar(8'h05, ".");
    endtask

    // ********************
    // main sequence
    // ********************
    initial
    begin
        rst     = 1'b1;
        keyClk  = 1'b1;
        keyData = 1'b1;
        cs      = 1'b0;
        address = 1'b0;
        seed    = 32'h42ea07c3;
        errors  = 0;
        repeat (2) @(posedge clk25);
        @(negedge clk25);
        rst = 1'b0;

        testReset();
        testUnshifted();
        testShift();
        testDebounce();
        testParity();
        testPrefixes();

        $display("errors: %0d", errors);
        if (errors == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

    // run length limit
    initial
    begin
        #(watchdogTime);
        $display("watchdog expired at time %0t before the tests finished", $time);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/ps2KeyPkg.sv
rtl/ps2Receiver.sv
rtl/keyStateTracker.sv
rtl/scanTranslator.sv
rtl/hostPort.sv
rtl/ps2Keyboard.sv
test/ps2KeyboardTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module ps2KeyboardTb --Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1
cat sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation result: PASS"
else
    echo "simulation result: FAIL"
    exit 1
fi
